// ==== verif/tcore_decode_patterns.txt ====
// column 1 instruction word, column 2 expected packed 22-bit control word zero padded to 32 bits
// control word msb first: in1_sel[21:20] in2_sel[19] alu[18:14] pc[13:10] imm[9:7] rf[6] wr[5] res[4:3] size[2:1] sign[0]
003100b3 00000040  // add   x1, x2, x3
403100b3 00004040  // sub   x1, x2, x3
003150b3 00018040  // srl   x1, x2, x3
403150b3 0001c040  // sra   x1, x2, x3
023100b3 00028040  // mul   x1, x2, x3
023170b3 00044040  // remu  x1, x2, x3
40010093 000800c0  // addi  x1, x2, 1024 (bit 30 set, still add)
00311093 00088140  // slli  x1, x2, 3
00315093 00098140  // srli  x1, x2, 3
40315093 0009c140  // srai  x1, x2, 3
00410083 000800cb  // lb    x1, 4(x2)
00411083 000800cd  // lh    x1, 4(x2)
00412083 000800ce  // lw    x1, 4(x2)
00414083 000800ca  // lbu   x1, 4(x2)
00415083 000800cc  // lhu   x1, 4(x2)
00310423 000801a2  // sb    x3, 8(x2)
00311423 000801a4  // sh    x3, 8(x2)
00312423 000801a6  // sw    x3, 8(x2)
00310463 00000600  // beq   x2, x3, 8
00311463 00000a00  // bne   x2, x3, 8
00314463 00000e00  // blt   x2, x3, 8
00315463 00001200  // bge   x2, x3, 8
00316463 00001600  // bltu  x2, x3, 8
00317463 00001a00  // bgeu  x2, x3, 8
010000ef 00002350  // jal   x1, 16
000100e7 00181cd0  // jalr  x1, 0(x2)
12345097 002802c0  // auipc x1, 0x12345
123450b7 000c82c0  // lui   x1, 0x12345
300110f3 00000000  // csrrw x1, 0x300, x2 (system, unsupported)
00000000 00000000  // all-zero word

// ==== tcore_decode.f ====
verilog/tcore_decode_pkg.sv
verilog/inst_fields_if.sv
verilog/inst_capture.sv
verilog/ctrl_decode.sv
verilog/ctrl_out_reg.sv
verilog/tcore_decode.sv
verif/tcore_decode_chk.sv
verif/tcore_decode_tb.sv

// ==== Bender.yml ====
package:
  name: tcore_decode

sources:
  - verilog/tcore_decode_pkg.sv
  - verilog/inst_fields_if.sv
  - verilog/inst_capture.sv
  - verilog/ctrl_decode.sv
  - verilog/ctrl_out_reg.sv
  - verilog/tcore_decode.sv
  - target: test
    files:
      - verif/tcore_decode_chk.sv
      - verif/tcore_decode_tb.sv

// ==== verif/tcore_decode_tb.sv ====
// run from the project root so the pattern file path resolves; fixed 2-cycle latency assumed
`default_nettype none

module tcore_decode_tb;

  localparam int          NUM_PAT    = 30;
  localparam int          LATENCY    = 2;
  localparam int          MAX_CYCLES = 2 * NUM_PAT + 64;
  localparam logic [31:0] SEED       = 32'h0509afd6;

  logic        clk_i;
  logic        rst_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        ctrl_valid_o;
  logic [1:0]  alu_in1_sel_o;
  logic        alu_in2_sel_o;
  logic [4:0]  alu_ctrl_o;
  logic [3:0]  pc_sel_o;
  logic [2:0]  imm_sel_o;
  logic        rf_rw_en_o;
  logic        wr_en_o;
  logic [1:0]  result_src_o;
  logic [1:0]  rw_size_o;
  logic        ld_op_sign_o;

  // instruction words at even entries and control words at odd ones
  logic [31:0] pat_mem [0:2*NUM_PAT-1];
  logic [31:0] inst_q [$];
  logic [21:0] exp_q [$];
  int          edge_q [$];
  logic [31:0] rand_state;
  int          cycle_cnt  = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          idx;

  tcore_decode tcore_decode_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .ctrl_valid_o  (ctrl_valid_o),
    .alu_in1_sel_o (alu_in1_sel_o),
    .alu_in2_sel_o (alu_in2_sel_o),
    .alu_ctrl_o    (alu_ctrl_o),
    .pc_sel_o      (pc_sel_o),
    .imm_sel_o     (imm_sel_o),
    .rf_rw_en_o    (rf_rw_en_o),
    .wr_en_o       (wr_en_o),
    .result_src_o  (result_src_o),
    .rw_size_o     (rw_size_o),
    .ld_op_sign_o  (ld_op_sign_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      value_errs++;
      $display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  // one compare per output port
  task automatic check_word(input logic [31:0] inst, input logic [21:0] exp,
                            input logic [21:0] act);
    compare_value($sformatf("alu_in1_sel_o for %08h", inst), act[21:20], exp[21:20]);
    compare_value($sformatf("alu_in2_sel_o for %08h", inst), act[19], exp[19]);
    compare_value($sformatf("alu_ctrl_o for %08h", inst), act[18:14], exp[18:14]);
    compare_value($sformatf("pc_sel_o for %08h", inst), act[13:10], exp[13:10]);
    compare_value($sformatf("imm_sel_o for %08h", inst), act[9:7], exp[9:7]);
    compare_value($sformatf("rf_rw_en_o for %08h", inst), act[6], exp[6]);
    compare_value($sformatf("wr_en_o for %08h", inst), act[5], exp[5]);
    compare_value($sformatf("result_src_o for %08h", inst), act[4:3], exp[4:3]);
    compare_value($sformatf("rw_size_o for %08h", inst), act[2:1], exp[2:1]);
    compare_value($sformatf("ld_op_sign_o for %08h", inst), act[0], exp[0]);
  endtask

  ////////////////////
  // cycle count and timeout
  ////////////////////
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d expected outputs missing",
               MAX_CYCLES, exp_q.size());
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////
  // output monitor
  ////////////////////
  // outputs sampled on the falling edge
  always @(negedge clk_i) begin : monitor
    logic [21:0] act;
    logic [21:0] exp;
    logic [31:0] inst;
    int          issued;
    act = {alu_in1_sel_o, alu_in2_sel_o, alu_ctrl_o, pc_sel_o, imm_sel_o,
           rf_rw_en_o, wr_en_o, result_src_o, rw_size_o, ld_op_sign_o};
    if (!rst_i) begin
      if (ctrl_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("extra valid output at %0t with no instruction outstanding", $time);
        end else begin
          exp    = exp_q.pop_front();
          inst   = inst_q.pop_front();
          issued = edge_q.pop_front();
          compare_value($sformatf("latency for %08h", inst), cycle_cnt - issued, LATENCY);
          check_word(inst, exp, act);
        end
      end else if (ctrl_valid_o === 1'b0) begin
        compare_value("rf_rw_en_o while idle", rf_rw_en_o, 1'b0);
        compare_value("wr_en_o while idle", wr_en_o, 1'b0);
      end else begin
        other_errs++;
        $display("ctrl_valid_o is unknown at %0t", $time);
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    rand_state   = SEED;
    $readmemh("verif/tcore_decode_patterns.txt", pat_mem);
    repeat (12) @(posedge clk_i);
    // a valid sw during the last reset cycles must be dropped
    inst_valid_i <= 1'b1;
    inst_i       <= 32'h00312423;
    repeat (4) @(posedge clk_i);
    rst_i        <= 1'b0;
    inst_valid_i <= 1'b0;
    inst_i       <= '0;
    // idle cycles before the first instruction
    repeat (3) @(posedge clk_i);
    if ($isunknown(pat_mem[2*NUM_PAT-1])) begin
      other_errs++;
      $display("pattern file verif/tcore_decode_patterns.txt could not be read in full");
    end else begin
      idx = 0;
      while (idx < NUM_PAT) begin
        @(posedge clk_i);
        rand_state = next_random(rand_state);
        if (rand_state[31:30] == 2'b00) begin
          // bubble with a junk instruction
          inst_valid_i <= 1'b0;
          inst_i       <= rand_state;
        end else begin
          inst_valid_i <= 1'b1;
          inst_i       <= pat_mem[2*idx];
          inst_q.push_back(pat_mem[2*idx]);
          exp_q.push_back(pat_mem[2*idx+1][21:0]);
          // index of the edge that presents this instruction
          edge_q.push_back(cycle_cnt + 1);
          idx++;
        end
      end
      @(posedge clk_i);
      inst_valid_i <= 1'b0;
      while (exp_q.size() != 0) begin
        @(posedge clk_i);
      end
      // watch for stray outputs after the drain
      repeat (LATENCY + 2) @(posedge clk_i);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tcore_decode_chk.sv ====
// assumes outputs settle one cycle after each reset edge; checks enables only outside reset
`default_nettype none

module tcore_decode_chk (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic ctrl_valid_i,
  input wire logic rf_rw_en_i,
  input wire logic wr_en_i
);

  ////////////////////
  // reset behavior
  ////////////////////
  valid_low_in_reset : assert property (@(posedge clk_i) rst_i |=> !ctrl_valid_i)
    else $error("ctrl_valid_o high during reset");

  // capture stage is still empty one cycle after release
  valid_low_after_reset : assert property (@(posedge clk_i) $fell(rst_i) |=> !ctrl_valid_i)
    else $error("ctrl_valid_o high in the cycle after reset");

  ////////////////////
  // write enables
  ////////////////////
  enables_exclusive : assert property (
    @(posedge clk_i) disable iff (rst_i) !(wr_en_i && rf_rw_en_i)
  ) else $error("wr_en_o and rf_rw_en_o high together");

  enables_need_valid : assert property (
    @(posedge clk_i) disable iff (rst_i) !ctrl_valid_i |-> (!wr_en_i && !rf_rw_en_i)
  ) else $error("write enable high without ctrl_valid_o");

endmodule

bind tcore_decode tcore_decode_chk tcore_decode_chk_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .ctrl_valid_i (ctrl_valid_o),
  .rf_rw_en_i   (rf_rw_en_o),
  .wr_en_i      (wr_en_o)
);

`default_nettype wire

// ==== verilog/tcore_decode.sv ====
// fixed two cycle decode latency, no back-pressure, csr/system opcodes decode as unknown
`default_nettype none

module tcore_decode
  import tcore_decode_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        inst_valid_i,
  input  wire logic [31:0] inst_i,
  output logic             ctrl_valid_o,
  output logic [1:0]       alu_in1_sel_o,
  output logic             alu_in2_sel_o,
  output logic [4:0]       alu_ctrl_o,
  output logic [3:0]       pc_sel_o,
  output logic [2:0]       imm_sel_o,
  output logic             rf_rw_en_o,
  output logic             wr_en_o,
  output logic [1:0]       result_src_o,
  output logic [1:0]       rw_size_o,
  output logic             ld_op_sign_o
);

  inst_fields_if fields ();

  logic  dec_valid;
  ctrl_t dec_ctrl;
  ctrl_t out_ctrl;

  ////////////////////
  // stages
  ////////////////////
  inst_capture inst_capture_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .fields_o     (fields.src)
  );

  ctrl_decode ctrl_decode_i (
    .fields_i (fields.dst),
    .valid_o  (dec_valid),
    .ctrl_o   (dec_ctrl)
  );

  ctrl_out_reg ctrl_out_reg_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (dec_valid),
    .ctrl_i  (dec_ctrl),
    .valid_o (ctrl_valid_o),
    .ctrl_o  (out_ctrl)
  );

  // unpack control word
  assign alu_in1_sel_o = out_ctrl.alu_in1_sel;
  assign alu_in2_sel_o = out_ctrl.alu_in2_sel;
  assign alu_ctrl_o    = out_ctrl.alu_ctrl;
  assign pc_sel_o      = out_ctrl.pc_sel;
  assign imm_sel_o     = out_ctrl.imm_sel;
  assign rf_rw_en_o    = out_ctrl.rf_rw_en;
  assign wr_en_o       = out_ctrl.wr_en;
  assign result_src_o  = out_ctrl.result_src;
  assign rw_size_o     = out_ctrl.rw_size;
  assign ld_op_sign_o  = out_ctrl.ld_op_sign;

endmodule

`default_nettype wire

// ==== verilog/ctrl_out_reg.sv ====
// one cycle latency; on invalid cycles fields hold but both write enables drop
`default_nettype none

module ctrl_out_reg
  import tcore_decode_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  input  wire logic  valid_i,
  input  wire ctrl_t ctrl_i,
  output logic       valid_o,
  output ctrl_t      ctrl_o
);

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      ctrl_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        ctrl_o <= ctrl_i;
      end else begin
        // bubble, no stale write to regfile or memory
        ctrl_o.rf_rw_en <= 1'b0;
        ctrl_o.wr_en    <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_decode.sv ====
// purely combinational; valid passes straight through, no csr support
`default_nettype none

module ctrl_decode
  import tcore_decode_pkg::*;
(
  inst_fields_if.dst  fields_i,
  output logic        valid_o,
  output ctrl_t       ctrl_o
);

  // base integer op from funct3, alt picks sub / sra
  function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    base_op = alt ? OP_SUB : OP_ADD;
      3'd1:    base_op = OP_SLL;
      3'd2:    base_op = OP_SLT;
      3'd3:    base_op = OP_SLTU;
      3'd4:    base_op = OP_XOR;
      3'd5:    base_op = alt ? OP_SRA : OP_SRL;
      3'd6:    base_op = OP_OR;
      default: base_op = OP_AND;
    endcase
  endfunction

  // m extension op from funct3
  function automatic alu_op_e mul_op(input logic [2:0] f3);
    case (f3)
      3'd0:    mul_op = OP_MUL;
      3'd1:    mul_op = OP_MULH;
      3'd2:    mul_op = OP_MULHSU;
      3'd3:    mul_op = OP_MULHU;
      3'd4:    mul_op = OP_DIV;
      3'd5:    mul_op = OP_DIVU;
      3'd6:    mul_op = OP_REM;
      default: mul_op = OP_REMU;
    endcase
  endfunction

  logic [2:0] f3;
  logic       is_shift_imm;

  assign f3           = fields_i.funct3;
  // slli, srli, srai
  assign is_shift_imm = (f3 == 3'd1) || (f3 == 3'd5);
  assign valid_o      = fields_i.valid;

  ////////////////////
  // control word
  ////////////////////
  always_comb begin
    // default word, also used for unknown opcodes
    ctrl_o             = '0;
    ctrl_o.alu_in1_sel = 2'd0;
    ctrl_o.alu_in2_sel = 1'b0;
    ctrl_o.alu_ctrl    = OP_ADD;
    ctrl_o.pc_sel      = NO_BJ;
    ctrl_o.imm_sel     = NO_IMM;
    ctrl_o.rf_rw_en    = 1'b0;
    ctrl_o.wr_en       = 1'b0;
    ctrl_o.result_src  = RES_ALU;
    ctrl_o.rw_size     = NO_SIZE;
    ctrl_o.ld_op_sign  = 1'b0;

    case (fields_i.cls)
      CLS_R: begin
        ctrl_o.rf_rw_en = 1'b1;
        if (fields_i.funct7_b0) begin
          ctrl_o.alu_ctrl = mul_op(f3);
        end else begin
          ctrl_o.alu_ctrl = base_op(f3, fields_i.funct7_b5);
        end
      end
      CLS_I: begin
        ctrl_o.rf_rw_en    = 1'b1;
        ctrl_o.alu_in2_sel = 1'b1;
        // addi ignores instr[30], only srai uses it
        ctrl_o.alu_ctrl    = base_op(f3, fields_i.funct7_b5 && (f3 == 3'd5));
        ctrl_o.imm_sel     = is_shift_imm ? I_USIMM : I_IMM;
      end
      CLS_LOAD: begin
        ctrl_o.rf_rw_en    = 1'b1;
        ctrl_o.alu_in2_sel = 1'b1;
        ctrl_o.imm_sel     = I_IMM;
        ctrl_o.result_src  = RES_MEM;
        case (f3)
          3'd0, 3'd4: ctrl_o.rw_size = BYTE;
          3'd1, 3'd5: ctrl_o.rw_size = HALF_WORD;
          3'd2:       ctrl_o.rw_size = WORD;
          default:    ctrl_o.rw_size = NO_SIZE;
        endcase
        // lb and lh sign extend
        ctrl_o.ld_op_sign  = (f3 == 3'd0) || (f3 == 3'd1);
      end
      CLS_STORE: begin
        ctrl_o.wr_en       = 1'b1;
        ctrl_o.alu_in2_sel = 1'b1;
        ctrl_o.imm_sel     = S_IMM;
        case (f3)
          3'd0:    ctrl_o.rw_size = BYTE;
          3'd1:    ctrl_o.rw_size = HALF_WORD;
          3'd2:    ctrl_o.rw_size = WORD;
          default: ctrl_o.rw_size = NO_SIZE;
        endcase
      end
      CLS_BRANCH: begin
        ctrl_o.imm_sel = B_IMM;
        case (f3)
          3'd0:    ctrl_o.pc_sel = BEQ;
          3'd1:    ctrl_o.pc_sel = BNE;
          3'd4:    ctrl_o.pc_sel = BLT;
          3'd5:    ctrl_o.pc_sel = BGE;
          3'd6:    ctrl_o.pc_sel = BLTU;
          3'd7:    ctrl_o.pc_sel = BGEU;
          default: ctrl_o.pc_sel = NO_BJ;
        endcase
      end
      CLS_LUI: begin
        ctrl_o.rf_rw_en    = 1'b1;
        ctrl_o.alu_in2_sel = 1'b1;
        ctrl_o.alu_ctrl    = OP_LUI;
        ctrl_o.imm_sel     = U_IMM;
      end
      CLS_AUIPC: begin
        ctrl_o.rf_rw_en    = 1'b1;
        // pc + upper immediate
        ctrl_o.alu_in1_sel = 2'd2;
        ctrl_o.alu_in2_sel = 1'b1;
        ctrl_o.imm_sel     = U_IMM;
      end
      CLS_JAL: begin
        ctrl_o.rf_rw_en   = 1'b1;
        ctrl_o.pc_sel     = JAL;
        ctrl_o.imm_sel    = J_IMM;
        ctrl_o.result_src = RES_PC4;
      end
      CLS_JALR: begin
        ctrl_o.rf_rw_en    = 1'b1;
        ctrl_o.alu_in1_sel = 2'd1;
        ctrl_o.alu_in2_sel = 1'b1;
        ctrl_o.pc_sel      = JALR;
        ctrl_o.imm_sel     = I_IMM;
        ctrl_o.result_src  = RES_PC4;
      end
      default: begin
        // CLS_NONE keeps the default word
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/inst_capture.sv ====
// one cycle latency; only valid is reset, class and funct fields are undefined until first load
`default_nettype none

module inst_capture
  import tcore_decode_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        inst_valid_i,
  input  wire logic [31:0] inst_i,
  inst_fields_if.src       fields_o
);

  logic [6:0]  opcode;
  inst_class_e cls_d;

  assign opcode = inst_i[6:0];

  ////////////////////
  // opcode class
  ////////////////////
  always_comb begin
    case (opcode)
      OPC_R:      cls_d = CLS_R;
      OPC_I:      cls_d = CLS_I;
      OPC_LOAD:   cls_d = CLS_LOAD;
      OPC_STORE:  cls_d = CLS_STORE;
      OPC_BRANCH: cls_d = CLS_BRANCH;
      OPC_LUI:    cls_d = CLS_LUI;
      OPC_AUIPC:  cls_d = CLS_AUIPC;
      OPC_JAL:    cls_d = CLS_JAL;
      OPC_JALR:   cls_d = CLS_JALR;
      // system, fence and reserved opcodes
      default:    cls_d = CLS_NONE;
    endcase
  end

  ////////////////////
  // capture register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fields_o.valid <= 1'b0;
    end else begin
      fields_o.valid <= inst_valid_i;
    end
  end

  // payload follows the input every cycle
  always_ff @(posedge clk_i) begin
    fields_o.cls       <= cls_d;
    fields_o.funct3    <= inst_i[14:12];
    fields_o.funct7_b5 <= inst_i[30];
    fields_o.funct7_b0 <= inst_i[25];
  end

endmodule

`default_nettype wire

// ==== verilog/inst_fields_if.sv ====
// classified fields only; raw opcode, register addresses and immediates are not carried
`default_nettype none

interface inst_fields_if
  import tcore_decode_pkg::*;
();

  logic        valid;
  inst_class_e cls;
  logic [2:0]  funct3;
  // instr[30], sub/sra select
  logic        funct7_b5;
  // instr[25], m extension select
  logic        funct7_b0;

  modport src (
    output valid, cls, funct3, funct7_b5, funct7_b0
  );

  modport dst (
    input valid, cls, funct3, funct7_b5, funct7_b0
  );

endinterface

`default_nettype wire

// ==== verilog/tcore_decode_pkg.sv ====
// rv32i plus m only; system/csr opcodes are not decoded and fall to the default control word
`default_nettype none

package tcore_decode_pkg;

  ////////////////////
  // base opcodes
  ////////////////////
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_I      = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // one-hot opcode class, CLS_NONE catches everything not listed
  typedef enum logic [9:0] {
    CLS_NONE   = 10'b00_0000_0001,
    CLS_R      = 10'b00_0000_0010,
    CLS_I      = 10'b00_0000_0100,
    CLS_LOAD   = 10'b00_0000_1000,
    CLS_STORE  = 10'b00_0001_0000,
    CLS_BRANCH = 10'b00_0010_0000,
    CLS_LUI    = 10'b00_0100_0000,
    CLS_AUIPC  = 10'b00_1000_0000,
    CLS_JAL    = 10'b01_0000_0000,
    CLS_JALR   = 10'b10_0000_0000
  } inst_class_e;

  ////////////////////
  // datapath encodings
  ////////////////////
  typedef enum logic [4:0] {
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_SLL    = 5'd2,
    OP_SLT    = 5'd3,
    OP_SLTU   = 5'd4,
    OP_XOR    = 5'd5,
    OP_SRL    = 5'd6,
    OP_SRA    = 5'd7,
    OP_OR     = 5'd8,
    OP_AND    = 5'd9,
    OP_MUL    = 5'd10,
    OP_MULH   = 5'd11,
    OP_MULHSU = 5'd12,
    OP_MULHU  = 5'd13,
    OP_DIV    = 5'd14,
    OP_DIVU   = 5'd15,
    OP_REM    = 5'd16,
    OP_REMU   = 5'd17,
    OP_LUI    = 5'd18
  } alu_op_e;

  typedef enum logic [3:0] {
    NO_BJ = 4'd0,
    BEQ   = 4'd1,
    BNE   = 4'd2,
    BLT   = 4'd3,
    BGE   = 4'd4,
    BLTU  = 4'd5,
    BGEU  = 4'd6,
    JALR  = 4'd7,
    JAL   = 4'd8
  } pc_sel_e;

  // I_USIMM is the unsigned shift amount
  typedef enum logic [2:0] {
    NO_IMM  = 3'd0,
    I_IMM   = 3'd1,
    I_USIMM = 3'd2,
    S_IMM   = 3'd3,
    B_IMM   = 3'd4,
    U_IMM   = 3'd5,
    J_IMM   = 3'd6
  } imm_sel_e;

  typedef enum logic [1:0] {
    NO_SIZE   = 2'd0,
    BYTE      = 2'd1,
    HALF_WORD = 2'd2,
    WORD      = 2'd3
  } rw_size_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } result_src_e;

  // 22-bit control word, alu_in1_sel 0 rs1, 1 rs1 for jalr, 2 pc
  typedef struct packed {
    logic [1:0]  alu_in1_sel;
    logic        alu_in2_sel;
    alu_op_e     alu_ctrl;
    pc_sel_e     pc_sel;
    imm_sel_e    imm_sel;
    logic        rf_rw_en;
    logic        wr_en;
    result_src_e result_src;
    rw_size_e    rw_size;
    logic        ld_op_sign;
  } ctrl_t;

endpackage

`default_nettype wire
